// ==== common/mhq_pkg.sv ====
/*
 * Shared definitions for the miss handling queue: data, address and queue
 * sizes, cache line geometry and the memory operation function type
 */

package mhq_pkg;

    // Word and address sizes
    localparam int DATA_WIDTH      = 32;
    localparam int ADDR_WIDTH      = 32;
    localparam int WORD_SIZE       = DATA_WIDTH / 8;

    // Queue depth and the width of an entry tag
    localparam int MHQ_DEPTH       = 4;
    localparam int MHQ_IDX_WIDTH   = $clog2(MHQ_DEPTH);

    // Data cache line geometry
    localparam int DC_LINE_SIZE    = 32;
    localparam int DC_LINE_WIDTH   = DC_LINE_SIZE * 8;
    localparam int DC_OFFSET_WIDTH = $clog2(DC_LINE_SIZE);

    // Memory operation issued by the LSU
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0011,
        LHU = 4'b0100,
        SB  = 4'b0101,
        SH  = 4'b0110,
        SW  = 4'b0111
    } lsu_func_t;

endpackage

// ==== files.f ====
common/mhq_pkg.sv
mhq/mhq_lu.sv
mhq/mhq_ex.sv
mhq/mhq.sv
tests/mhq_props.sv
tests/mhq_tb.sv

// ==== mhq/mhq.sv ====
/*
 * Miss handling queue top level. Joins the lookup and execute stages and
 * forms the CCU request address from the head line address
 */

`timescale 1ns/1ns

module mhq (
    input  logic                                clk,
    input  logic                                i_reset,

    // Lookup from the LSU
    input  logic                                i_lookup_valid,
    input  logic                                i_lookup_dc_hit,
    input  logic [mhq_pkg::ADDR_WIDTH-1:0]      i_lookup_addr,
    input  mhq_pkg::lsu_func_t                  i_lookup_lsu_func,
    input  logic [mhq_pkg::DATA_WIDTH-1:0]      i_lookup_data,
    input  logic                                i_lookup_we,
    output logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]   o_lookup_tag,
    output logic                                o_lookup_retry,

    // CCU line request
    input  logic                                i_ccu_done,
    input  logic [mhq_pkg::DC_LINE_WIDTH-1:0]   i_ccu_data,
    output logic                                o_ccu_en,
    output logic [mhq_pkg::ADDR_WIDTH-1:0]      o_ccu_addr,

    // Cache fill
    output logic                                o_fill_en,
    output logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]   o_fill_tag,
    output logic                                o_fill_dirty,
    output logic [mhq_pkg::ADDR_WIDTH-1:0]      o_fill_addr,
    output logic [mhq_pkg::DC_LINE_WIDTH-1:0]   o_fill_data
);

    logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       head_next;
    logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       tail_next;
    logic [mhq_pkg::MHQ_DEPTH-1:0]                         entry_valid;
    logic [mhq_pkg::MHQ_DEPTH-1:0]
          [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] entry_line_addr;
    logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] ccu_line_addr;
    logic                                                  lu_en;
    logic                                                  lu_we;
    logic [mhq_pkg::DC_OFFSET_WIDTH-1:0]                   lu_offset;
    logic [mhq_pkg::DATA_WIDTH-1:0]                        lu_wr_data;
    logic [mhq_pkg::WORD_SIZE-1:0]                         lu_byte_select;
    logic                                                  lu_match;
    logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]                     lu_tag;
    logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] lu_line_addr;

    assign o_ccu_addr   = {ccu_line_addr, {mhq_pkg::DC_OFFSET_WIDTH{1'b0}}};
    assign o_lookup_tag = lu_tag;

    // The lookup outputs double as the bypass of the allocation in execute
    mhq_lu u_mhq_lu (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_lookup_valid    (i_lookup_valid),
        .i_lookup_dc_hit   (i_lookup_dc_hit),
        .i_lookup_addr     (i_lookup_addr),
        .i_lookup_lsu_func (i_lookup_lsu_func),
        .i_lookup_data     (i_lookup_data),
        .i_lookup_we       (i_lookup_we),
        .i_head_next       (head_next),
        .i_tail_next       (tail_next),
        .i_entry_valid     (entry_valid),
        .i_entry_line_addr (entry_line_addr),
        .i_ex_en           (lu_en),
        .i_ex_match        (lu_match),
        .i_ex_tag          (lu_tag),
        .i_ex_line_addr    (lu_line_addr),
        .i_ccu_done        (i_ccu_done),
        .i_ccu_line_addr   (ccu_line_addr),
        .o_lu_en           (lu_en),
        .o_lu_we           (lu_we),
        .o_lu_offset       (lu_offset),
        .o_lu_wr_data      (lu_wr_data),
        .o_lu_byte_select  (lu_byte_select),
        .o_lu_match        (lu_match),
        .o_lu_tag          (lu_tag),
        .o_lu_line_addr    (lu_line_addr),
        .o_lu_retry        (o_lookup_retry)
    );

    mhq_ex u_mhq_ex (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_lu_en           (lu_en),
        .i_lu_we           (lu_we),
        .i_lu_offset       (lu_offset),
        .i_lu_wr_data      (lu_wr_data),
        .i_lu_byte_select  (lu_byte_select),
        .i_lu_match        (lu_match),
        .i_lu_tag          (lu_tag),
        .i_lu_line_addr    (lu_line_addr),
        .i_ccu_done        (i_ccu_done),
        .i_ccu_data        (i_ccu_data),
        .o_head_next       (head_next),
        .o_tail_next       (tail_next),
        .o_entry_valid     (entry_valid),
        .o_entry_line_addr (entry_line_addr),
        .o_ccu_en          (o_ccu_en),
        .o_ccu_line_addr   (ccu_line_addr),
        .o_fill_en         (o_fill_en),
        .o_fill_tag        (o_fill_tag),
        .o_fill_dirty      (o_fill_dirty),
        .o_fill_addr       (o_fill_addr),
        .o_fill_data       (o_fill_data)
    );

endmodule

// ==== mhq/mhq_ex.sv ====
/*
 * Execute stage of the miss handling queue. Holds the entries, allocates
 * or merges lookup requests, writes store bytes, requests the head line
 * from the CCU and merges the returned line into a cache fill
 */

`timescale 1ns/1ns

module mhq_ex (
    input  logic                                                  clk,
    input  logic                                                  i_reset,

    input  logic                                                  i_lu_en,
    input  logic                                                  i_lu_we,
    input  logic [mhq_pkg::DC_OFFSET_WIDTH-1:0]                   i_lu_offset,
    input  logic [mhq_pkg::DATA_WIDTH-1:0]                        i_lu_wr_data,
    input  logic [mhq_pkg::WORD_SIZE-1:0]                         i_lu_byte_select,
    input  logic                                                  i_lu_match,
    input  logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]                     i_lu_tag,
    input  logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] i_lu_line_addr,

    input  logic                                                  i_ccu_done,
    input  logic [mhq_pkg::DC_LINE_WIDTH-1:0]                     i_ccu_data,

    output logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       o_head_next,
    output logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       o_tail_next,
    output logic [mhq_pkg::MHQ_DEPTH-1:0]                         o_entry_valid,
    output logic [mhq_pkg::MHQ_DEPTH-1:0]
                 [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] o_entry_line_addr,

    output logic                                                  o_ccu_en,
    output logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] o_ccu_line_addr,

    output logic                                                  o_fill_en,
    output logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]                     o_fill_tag,
    output logic                                                  o_fill_dirty,
    output logic [mhq_pkg::ADDR_WIDTH-1:0]                        o_fill_addr,
    output logic [mhq_pkg::DC_LINE_WIDTH-1:0]                     o_fill_data
);

    logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]   head_idx;
    logic [mhq_pkg::DC_LINE_SIZE-1:0]    wr_mask;
    logic [mhq_pkg::DC_LINE_WIDTH-1:0]   wr_line;
    logic                                head_wr;
    logic [mhq_pkg::DC_LINE_WIDTH-1:0]   fill_data;
    logic                                fill_dirty;
    logic [mhq_pkg::MHQ_DEPTH-1:0]       entry_dirty;
    logic [mhq_pkg::DC_LINE_SIZE-1:0]    entry_mask [mhq_pkg::MHQ_DEPTH];
    logic [mhq_pkg::DC_LINE_WIDTH-1:0]   entry_data [mhq_pkg::MHQ_DEPTH];

    assign head_idx = o_head_next[mhq_pkg::MHQ_IDX_WIDTH-1:0];

    // Place the store word at its offset within the line
    assign wr_mask = i_lu_we ? ({{(mhq_pkg::DC_LINE_SIZE - mhq_pkg::WORD_SIZE){1'b0}},
                                 i_lu_byte_select} << i_lu_offset) : '0;
    assign wr_line = {{(mhq_pkg::DC_LINE_WIDTH - mhq_pkg::DATA_WIDTH){1'b0}}, i_lu_wr_data}
                     << {i_lu_offset, 3'b000};

    // The CCU is idle during the fill cycle, so the next request starts a cycle later
    assign o_ccu_en        = o_entry_valid[head_idx] & ~o_fill_en;
    assign o_ccu_line_addr = o_entry_line_addr[head_idx];

    // A store merging into the head at the fill edge goes straight into the fill
    assign head_wr = i_lu_en & i_lu_match & (i_lu_tag == head_idx);

    always_comb begin
        for (int b = 0; b < mhq_pkg::DC_LINE_SIZE; b++) begin
            if (head_wr && wr_mask[b]) begin
                fill_data[b*8 +: 8] = wr_line[b*8 +: 8];
            end else if (entry_mask[head_idx][b]) begin
                fill_data[b*8 +: 8] = entry_data[head_idx][b*8 +: 8];
            end else begin
                fill_data[b*8 +: 8] = i_ccu_data[b*8 +: 8];
            end
        end
        fill_dirty = entry_dirty[head_idx] | (head_wr & i_lu_we);
    end

    // Queue pointers and entry valids
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_head_next   <= '0;
            o_tail_next   <= '0;
            o_entry_valid <= '0;
            o_fill_en     <= 1'b0;
        end else begin
            o_fill_en <= i_ccu_done;
            if (i_lu_en && !i_lu_match) begin
                o_entry_valid[i_lu_tag] <= 1'b1;
                o_tail_next             <= o_tail_next + 1'b1;
            end
            if (i_ccu_done) begin
                o_entry_valid[head_idx] <= 1'b0;
                o_head_next             <= o_head_next + 1'b1;
            end
        end
    end

    // Entry contents. A new entry starts with only the bytes of its own store
    always_ff @(posedge clk) begin
        if (i_lu_en) begin
            if (i_lu_match) begin
                entry_mask[i_lu_tag]  <= entry_mask[i_lu_tag] | wr_mask;
                entry_dirty[i_lu_tag] <= entry_dirty[i_lu_tag] | i_lu_we;
            end else begin
                o_entry_line_addr[i_lu_tag] <= i_lu_line_addr;
                entry_mask[i_lu_tag]        <= wr_mask;
                entry_dirty[i_lu_tag]       <= i_lu_we;
            end
            for (int b = 0; b < mhq_pkg::DC_LINE_SIZE; b++) begin
                if (wr_mask[b]) begin
                    entry_data[i_lu_tag][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
        end
    end

    // Fill payload, captured when the CCU returns the head line
    always_ff @(posedge clk) begin
        if (i_ccu_done) begin
            o_fill_tag   <= head_idx;
            o_fill_dirty <= fill_dirty;
            o_fill_addr  <= {o_entry_line_addr[head_idx], {mhq_pkg::DC_OFFSET_WIDTH{1'b0}}};
            o_fill_data  <= fill_data;
        end
    end

endmodule

// ==== mhq/mhq_lu.sv ====
/*
 * Lookup stage of the miss handling queue. Matches the request line
 * against all valid entries and the allocation in execute, then
 * registers the tag, retry and byte-aligned store data for execute
 */

`timescale 1ns/1ns

module mhq_lu (
    input  logic                                                  clk,
    input  logic                                                  i_reset,

    input  logic                                                  i_lookup_valid,
    input  logic                                                  i_lookup_dc_hit,
    input  logic [mhq_pkg::ADDR_WIDTH-1:0]                        i_lookup_addr,
    input  mhq_pkg::lsu_func_t                                    i_lookup_lsu_func,
    input  logic [mhq_pkg::DATA_WIDTH-1:0]                        i_lookup_data,
    input  logic                                                  i_lookup_we,

    input  logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       i_head_next,
    input  logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       i_tail_next,
    input  logic [mhq_pkg::MHQ_DEPTH-1:0]                         i_entry_valid,
    input  logic [mhq_pkg::MHQ_DEPTH-1:0]
                 [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] i_entry_line_addr,

    input  logic                                                  i_ex_en,
    input  logic                                                  i_ex_match,
    input  logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]                     i_ex_tag,
    input  logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] i_ex_line_addr,

    input  logic                                                  i_ccu_done,
    input  logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] i_ccu_line_addr,

    output logic                                                  o_lu_en,
    output logic                                                  o_lu_we,
    output logic [mhq_pkg::DC_OFFSET_WIDTH-1:0]                   o_lu_offset,
    output logic [mhq_pkg::DATA_WIDTH-1:0]                        o_lu_wr_data,
    output logic [mhq_pkg::WORD_SIZE-1:0]                         o_lu_byte_select,
    output logic                                                  o_lu_match,
    output logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]                     o_lu_tag,
    output logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] o_lu_line_addr,
    output logic                                                  o_lu_retry
);

    logic                                                  req_en;
    logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] req_line_addr;
    logic [mhq_pkg::DC_OFFSET_WIDTH-1:0]                   lane_mask;
    logic [mhq_pkg::DC_OFFSET_WIDTH-1:0]                   byte_lane;
    logic [mhq_pkg::WORD_SIZE-1:0]                         byte_select;
    logic                                                  cam_match;
    logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]                     cam_tag;
    logic                                                  bypass_hit;
    logic                                                  pending_alloc;
    logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       occupancy;
    logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       alloc_ptr;
    logic                                                  full;
    logic                                                  fill_conflict;
    logic                                                  match;
    logic                                                  retry;

    assign req_en        = i_lookup_valid & ~i_lookup_dc_hit;
    assign req_line_addr = i_lookup_addr[mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH];
    assign lane_mask     = mhq_pkg::DC_OFFSET_WIDTH'(mhq_pkg::WORD_SIZE - 1);
    assign byte_lane     = i_lookup_addr[mhq_pkg::DC_OFFSET_WIDTH-1:0] & lane_mask;

    // Compare the request line with every valid entry
    always_comb begin
        cam_match = 1'b0;
        cam_tag   = '0;
        for (int i = 0; i < mhq_pkg::MHQ_DEPTH; i++) begin
            if (i_entry_valid[i] && (i_entry_line_addr[i] == req_line_addr)) begin
                cam_match = 1'b1;
                cam_tag   = mhq_pkg::MHQ_IDX_WIDTH'(i);
            end
        end
    end

    // Execute writes its entry at the next edge, so the CAM cannot see it yet
    assign bypass_hit    = i_ex_en & (i_ex_line_addr == req_line_addr);
    assign pending_alloc = i_ex_en & ~i_ex_match;
    assign match         = cam_match | bypass_hit;

    // The depth is a power of two, so a full queue sets the top occupancy bit
    assign occupancy = i_tail_next - i_head_next
                     + {{mhq_pkg::MHQ_IDX_WIDTH{1'b0}}, pending_alloc};
    assign alloc_ptr = i_tail_next + {{mhq_pkg::MHQ_IDX_WIDTH{1'b0}}, pending_alloc};
    assign full      = occupancy[mhq_pkg::MHQ_IDX_WIDTH];

    // The head entry is freed at this edge and cannot take a merge
    assign fill_conflict = i_ccu_done & (i_ccu_line_addr == req_line_addr);
    assign retry         = req_en & ((full & ~match) | fill_conflict);

    always_comb begin
        case (i_lookup_lsu_func)
            mhq_pkg::LB, mhq_pkg::LBU, mhq_pkg::SB: byte_select = mhq_pkg::WORD_SIZE'(1);
            mhq_pkg::LH, mhq_pkg::LHU, mhq_pkg::SH: byte_select = mhq_pkg::WORD_SIZE'(3);
            default:                                byte_select = '1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_lu_en    <= 1'b0;
            o_lu_retry <= 1'b0;
        end else begin
            o_lu_en    <= req_en & ~retry;
            o_lu_retry <= retry;
        end
    end

    // Store data and byte select are aligned to their lanes within the word
    always_ff @(posedge clk) begin
        o_lu_we          <= i_lookup_we;
        o_lu_offset      <= i_lookup_addr[mhq_pkg::DC_OFFSET_WIDTH-1:0] & ~lane_mask;
        o_lu_wr_data     <= i_lookup_data << {byte_lane, 3'b000};
        o_lu_byte_select <= byte_select << byte_lane;
        o_lu_match       <= match;
        o_lu_tag         <= bypass_hit ? i_ex_tag :
                            cam_match  ? cam_tag  : alloc_ptr[mhq_pkg::MHQ_IDX_WIDTH-1:0];
        o_lu_line_addr   <= req_line_addr;
    end

endmodule

// ==== tests/mhq_props.sv ====
/*
 * Concurrent assertions on the execute stage of the miss handling queue:
 * reset state, fill pulse width and CCU request stability
 */

`timescale 1ns/1ns

module mhq_props (
    input logic                                                  clk,
    input logic                                                  i_reset,
    input logic                                                  i_ccu_en,
    input logic [mhq_pkg::ADDR_WIDTH-1:mhq_pkg::DC_OFFSET_WIDTH] i_ccu_line_addr,
    input logic                                                  i_fill_en,
    input logic [mhq_pkg::MHQ_DEPTH-1:0]                         i_entry_valid,
    input logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       i_head_next,
    input logic [mhq_pkg::MHQ_IDX_WIDTH:0]                       i_tail_next
);

    // Number of failed assertions
    int fail_count = 0;

    reset_state: assert property (@(posedge clk)
        i_reset |=> (!i_ccu_en && !i_fill_en && (i_entry_valid == '0)
                     && (i_head_next == '0) && (i_tail_next == '0)))
        else begin
            fail_count++;
            $error("Queue state is not cleared after reset");
        end

    fill_one_cycle: assert property (@(posedge clk) disable iff (i_reset)
        i_fill_en |=> !i_fill_en)
        else begin
            fail_count++;
            $error("Fill pulse lasts longer than one cycle");
        end

    ccu_addr_stable: assert property (@(posedge clk) disable iff (i_reset)
        i_ccu_en ##1 i_ccu_en |-> $stable(i_ccu_line_addr))
        else begin
            fail_count++;
            $error("CCU request address changed while the request was held");
        end

endmodule

bind mhq_ex mhq_props u_mhq_props (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_ccu_en        (o_ccu_en),
    .i_ccu_line_addr (o_ccu_line_addr),
    .i_fill_en       (o_fill_en),
    .i_entry_valid   (o_entry_valid),
    .i_head_next     (o_head_next),
    .i_tail_next     (o_tail_next)
);

// ==== tests/mhq_tb.sv ====
/*
 * Testbench for the miss handling queue. Reads lookups, CCU lines and
 * expected results from a data file, models the CCU with a random
 * latency and prints a closing error report
 */

`timescale 1ns/1ns

module mhq_tb;

    localparam int WAIT_LIMIT = 200;

    logic                                    clk;
    logic                                    i_reset;
    logic                                    i_lookup_valid;
    logic                                    i_lookup_dc_hit;
    logic [mhq_pkg::ADDR_WIDTH-1:0]          i_lookup_addr;
    mhq_pkg::lsu_func_t                      i_lookup_lsu_func;
    logic [mhq_pkg::DATA_WIDTH-1:0]          i_lookup_data;
    logic                                    i_lookup_we;
    logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]       o_lookup_tag;
    logic                                    o_lookup_retry;
    logic                                    i_ccu_done;
    logic [mhq_pkg::DC_LINE_WIDTH-1:0]       i_ccu_data;
    logic                                    o_ccu_en;
    logic [mhq_pkg::ADDR_WIDTH-1:0]          o_ccu_addr;
    logic                                    o_fill_en;
    logic [mhq_pkg::MHQ_IDX_WIDTH-1:0]       o_fill_tag;
    logic                                    o_fill_dirty;
    logic [mhq_pkg::ADDR_WIDTH-1:0]          o_fill_addr;
    logic [mhq_pkg::DC_LINE_WIDTH-1:0]       o_fill_data;

    int errors;
    int timeouts;
    int fill_count;
    int fills_expected;

    mhq u_mhq (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Every fill pulse is counted, also one that the data file does not expect
    always @(negedge clk) begin
        if (!i_reset && o_fill_en) begin
            fill_count++;
        end
    end

    task automatic check_value(input logic [mhq_pkg::DC_LINE_WIDTH-1:0] actual,
                               input logic [mhq_pkg::DC_LINE_WIDTH-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic issue_lookup(input logic [mhq_pkg::ADDR_WIDTH-1:0] addr,
                                input logic [3:0] func,
                                input logic [mhq_pkg::DATA_WIDTH-1:0] data,
                                input logic we,
                                input logic dc_hit,
                                input logic [mhq_pkg::MHQ_IDX_WIDTH-1:0] tag,
                                input logic retry);
        i_lookup_valid    = 1'b1;
        i_lookup_dc_hit   = dc_hit;
        i_lookup_addr     = addr;
        i_lookup_lsu_func = mhq_pkg::lsu_func_t'(func);
        i_lookup_data     = data;
        i_lookup_we       = we;
        @(posedge clk);
        #1;
        i_lookup_valid  = 1'b0;
        i_lookup_dc_hit = 1'b0;
        i_lookup_we     = 1'b0;
        // Tag and retry only carry meaning for a miss, and the tag only without retry
        if (!dc_hit) begin
            check_value(o_lookup_retry, retry, $sformatf("retry of lookup %h", addr));
            if (!retry) begin
                check_value(o_lookup_tag, tag, $sformatf("tag of lookup %h", addr));
            end
        end
    endtask

    task automatic serve_fill(input logic [mhq_pkg::ADDR_WIDTH-1:0] addr,
                              input logic [mhq_pkg::DC_LINE_WIDTH-1:0] ccu_line,
                              input logic [mhq_pkg::MHQ_IDX_WIDTH-1:0] tag,
                              input logic dirty,
                              input logic [mhq_pkg::DC_LINE_WIDTH-1:0] fill_line);
        int waited;
        int latency;
        waited = 0;
        while (!o_ccu_en && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!o_ccu_en) begin
            timeouts++;
            $display("Timeout at %0t ns: no CCU request came for line %h", $time, addr);
        end else begin
            check_value(o_ccu_addr, addr, "CCU request address");
            latency = $urandom % 4;
            repeat (latency) begin
                @(posedge clk);
                #1;
            end
            i_ccu_done = 1'b1;
            i_ccu_data = ccu_line;
            @(posedge clk);
            #1;
            i_ccu_done = 1'b0;
            waited = 0;
            while (!o_fill_en && waited < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!o_fill_en) begin
                timeouts++;
                $display("Timeout at %0t ns: no fill came for line %h", $time, addr);
            end else begin
                check_value(o_fill_tag, tag, "fill tag");
                check_value(o_fill_addr, addr, "fill address");
                check_value(o_fill_dirty, dirty, "fill dirty flag");
                check_value(o_fill_data, fill_line, "fill data");
            end
        end
    endtask

    initial begin
        string                             line;
        int                                fd;
        int                                fields;
        int                                seed;
        int                                assert_fails;
        logic [mhq_pkg::ADDR_WIDTH-1:0]    addr;
        logic [3:0]                        func;
        logic [mhq_pkg::DATA_WIDTH-1:0]    data;
        logic                              we;
        logic                              dc_hit;
        logic [mhq_pkg::MHQ_IDX_WIDTH-1:0] tag;
        logic                              expect_bit;
        logic [mhq_pkg::DC_LINE_WIDTH-1:0] ccu_line;
        logic [mhq_pkg::DC_LINE_WIDTH-1:0] fill_line;

        errors            = 0;
        timeouts          = 0;
        fill_count        = 0;
        fills_expected    = 0;
        seed              = $urandom(32'h04ad_410e);
        i_reset           = 1'b1;
        i_lookup_valid    = 1'b0;
        i_lookup_dc_hit   = 1'b0;
        i_lookup_addr     = '0;
        i_lookup_lsu_func = mhq_pkg::LB;
        i_lookup_data     = '0;
        i_lookup_we       = 1'b0;
        i_ccu_done        = 1'b0;
        i_ccu_data        = '0;
        repeat (10) @(posedge clk);
        #1;
        i_reset = 1'b0;
        check_value(o_ccu_en, 1'b0, "CCU request after reset");
        check_value(o_fill_en, 1'b0, "fill after reset");
        check_value(o_lookup_retry, 1'b0, "retry after reset");

        fd = $fopen("tests/mhq_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the data file tests/mhq_testdata.txt");
        end else begin
            while (timeouts == 0 && $fgets(line, fd) != 0) begin
                if (line[0] == "L") begin
                    fields = $sscanf(line, "L %h %h %h %h %h %h %h",
                                     addr, func, data, we, dc_hit, tag, expect_bit);
                    if (fields == 7) begin
                        issue_lookup(addr, func, data, we, dc_hit, tag, expect_bit);
                    end else begin
                        errors++;
                        $display("Malformed lookup line in data file: %s", line);
                    end
                end else if (line[0] == "F") begin
                    fills_expected++;
                    fields = $sscanf(line, "F %h %h %h %h %h",
                                     addr, ccu_line, tag, expect_bit, fill_line);
                    if (fields == 5) begin
                        serve_fill(addr, ccu_line, tag, expect_bit, fill_line);
                    end else begin
                        errors++;
                        $display("Malformed fill line in data file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (3) @(posedge clk);
        if (timeouts == 0) begin
            check_value(fill_count, fills_expected, "number of fill pulses");
        end
        assert_fails = u_mhq.u_mhq_ex.u_mhq_props.fail_count;
        $display("Errors: %0d failed checks, %0d assertion failures, %0d timeouts",
                 errors, assert_fails, timeouts);
        if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tests/mhq_testdata.txt ====
# L addr func data we dc_hit tag retry  (func: 0 LB 1 LH 2 LW 3 LBU 4 LHU 5 SB 6 SH 7 SW)
# F ccu_addr ccu_line tag dirty fill_line  (lines are 64 hex digits, byte 31 first)
L 00001000 2 00000000 0 0 0 0
L 00001005 5 000000aa 1 0 0 0
L 00002000 2 00000000 0 0 1 0
L 00002010 6 0000beef 1 0 1 0
L 00003000 3 00000000 0 0 2 0
L 00004004 7 12345678 1 0 3 0
L 00005000 2 00000000 0 0 0 1
L 00003008 2 00000000 0 1 0 0
L 00002004 1 00000000 0 0 1 0
L 0000100c 7 cafef00d 1 0 0 0
F 00001000 1f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100 0 1 1f1e1d1c1b1a19181716151413121110cafef00d0b0a09080706aa0403020100
L 00005000 2 00000000 0 0 0 0
F 00002000 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 1 1 a5a5a5a5a5a5a5a5a5a5a5a5a5a5beefa5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
F 00003000 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef 2 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
F 00004000 0000000000000000000000000000000000000000000000000000000000000000 3 1 0000000000000000000000000000000000000000000000001234567800000000
F 00005000 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0 0 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
